/* design/smc_pkg.sv */
// Shared constants for the static memory controller
// Single chip select, single transfers only
// Wait fields are 4 bits, so strobes last 1 to 16 cycles
`default_nettype none

package smc_pkg;

  // ----------------------------
  // AHB encodings
  // ----------------------------
  // Transfer type, only bit 1 marks an active transfer
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // Slave response
  localparam logic [1:0] hresp_okay  = 2'b00;
  localparam logic [1:0] hresp_error = 2'b01;

  // ----------------------------
  // APB register map
  // ----------------------------
  localparam logic [4:0] reg_timing_addr = 5'h00;  // rd_wait 3:0, wr_wait 7:4
  localparam logic [4:0] reg_count_addr  = 5'h04;  // Completed accesses, read only

  // ----------------------------
  // Strobe timing
  // ----------------------------
  localparam int wait_width = 4;

  // Reset waits give a 3-cycle strobe
  localparam logic [wait_width-1:0] rd_wait_reset = 4'd2;
  localparam logic [wait_width-1:0] wr_wait_reset = 4'd2;

endpackage

`default_nettype wire

/* design/smc_apb_regs.sv */
// APB register block for EMI strobe timing and access count
// APB runs on hclk, no wait states, pready not used
// Unknown offsets read zero, count register ignores writes
`timescale 1ns/1ns
`default_nettype none

module smc_apb_regs (
  input  logic                           hclk,
  input  logic                           arst_n,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [4:0]                     paddr,
  input  logic [31:0]                    pwdata,
  input  logic                           done,     // One pulse per finished EMI access
  output logic [31:0]                    prdata,
  output logic [smc_pkg::wait_width-1:0] rd_wait,
  output logic [smc_pkg::wait_width-1:0] wr_wait
);

  localparam int tw = 2 * smc_pkg::wait_width;  // Timing register width

  logic [tw-1:0] timing_q;  // {wr_wait, rd_wait}
  logic [31:0]   count_q;
  logic          wr_en;

  // Access phase of an APB write
  assign wr_en = psel & penable & pwrite;

  // ----------------------------
  // Registers
  // ----------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      timing_q <= {smc_pkg::wr_wait_reset, smc_pkg::rd_wait_reset};
      count_q  <= '0;
    end else begin
      if (wr_en && (paddr == smc_pkg::reg_timing_addr)) begin
        timing_q <= pwdata[tw-1:0];
      end
      if (done) begin
        count_q <= count_q + 32'd1;  // Wraps at 2^32
      end
    end
  end

  assign rd_wait = timing_q[smc_pkg::wait_width-1:0];
  assign wr_wait = timing_q[tw-1:smc_pkg::wait_width];

  // Read-back, combinational while selected
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        smc_pkg::reg_timing_addr: prdata = {{(32 - tw){1'b0}}, timing_q};
        smc_pkg::reg_count_addr:  prdata = count_q;
        default:                  prdata = '0;  // Unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/smc_ahb_slave.sv */
// AHB-lite slave front end of the memory controller
// Single transfers only, one outstanding access at a time
// Sizes above word or misaligned addresses get a two-cycle ERROR
// hwdata must stay stable for the whole data phase
`timescale 1ns/1ns
`default_nettype none

module smc_ahb_slave (
  input  logic        hclk,
  input  logic        arst_n,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,      // Muxed bus ready
  input  logic        done,        // EMI access finished
  input  logic [31:0] rdata,       // EMI read data, valid with done
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  output logic        start,       // One-cycle EMI kick
  output logic [31:0] addr,
  output logic        write,
  output logic [31:0] wdata,
  output logic [3:0]  byte_lanes   // Active high
);

  logic       accept;     // Address phase taken this cycle
  logic       legal;      // Size and alignment ok
  logic [3:0] lanes_dec;
  logic       err_first;  // First ERROR cycle, hready low
  logic       wait_emi;   // Waiting for done

  // Only take a new transfer when our own data phase is complete
  assign accept = hsel & htrans[1] & hready & smc_hready;

  // ----------------------------
  // Address phase decode
  // ----------------------------
  always_comb begin
    case (hsize)
      3'd0:    legal = 1'b1;
      3'd1:    legal = ~haddr[0];
      3'd2:    legal = (haddr[1:0] == 2'b00);
      default: legal = 1'b0;  // Wider than the bus
    endcase
  end

  always_comb begin
    case (hsize[1:0])
      2'd0:    lanes_dec = 4'b0001 << haddr[1:0];         // Byte
      2'd1:    lanes_dec = haddr[1] ? 4'b1100 : 4'b0011;  // Half-word
      default: lanes_dec = 4'b1111;                       // Word
    endcase
  end

  assign smc_valid = accept & legal;
  assign wdata     = hwdata;  // Held by master through data phase

  // ----------------------------
  // Ready and response sequencing
  // ----------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      smc_hready <= 1'b1;
      smc_hresp  <= smc_pkg::hresp_okay;
      start      <= 1'b0;
      err_first  <= 1'b0;
      wait_emi   <= 1'b0;
    end else begin
      start <= accept & legal;
      if (accept) begin
        smc_hready <= 1'b0;
        smc_hresp  <= legal ? smc_pkg::hresp_okay : smc_pkg::hresp_error;
        err_first  <= ~legal;
        wait_emi   <= legal;
      end else if (err_first) begin
        err_first  <= 1'b0;
        smc_hready <= 1'b1;  // Second ERROR cycle
      end else if (wait_emi && done) begin
        wait_emi   <= 1'b0;
        smc_hready <= 1'b1;
      end else if (smc_hready) begin
        smc_hresp  <= smc_pkg::hresp_okay;
      end
    end
  end

  // Captured transfer and read data
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr       <= haddr;
      write      <= hwrite;
      byte_lanes <= lanes_dec;
    end
    if (wait_emi && done) begin
      smc_hrdata <= rdata;
    end
  end

endmodule

`default_nettype wire

/* design/smc_emi_fsm.sv */
// EMI timing engine for one asynchronous SRAM device
// SETUP 1 cycle, STROBE wait+1 cycles, HOLD 1 cycle
// start is only honoured in IDLE
// All pins come straight from flops
`timescale 1ns/1ns
`default_nettype none

module smc_emi_fsm (
  input  logic                           hclk,
  input  logic                           arst_n,
  input  logic                           start,
  input  logic [31:0]                    addr,
  input  logic                           write,
  input  logic [31:0]                    wdata,
  input  logic [3:0]                     byte_lanes,
  input  logic [smc_pkg::wait_width-1:0] rd_wait,
  input  logic [smc_pkg::wait_width-1:0] wr_wait,
  input  logic [31:0]                    data_smc,     // From device
  output logic                           done,
  output logic [31:0]                    rdata,
  output logic [31:0]                    smc_addr,
  output logic [31:0]                    smc_data,
  output logic [3:0]                     smc_n_be,
  output logic                           smc_n_cs,
  output logic [3:0]                     smc_n_we,
  output logic                           smc_n_wr,
  output logic                           smc_n_rd,
  output logic                           smc_n_ext_oe,
  output logic                           smc_busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_strobe,
    st_hold
  } state_t;

  state_t                         state;
  logic [smc_pkg::wait_width-1:0] cnt;      // Strobe cycles left minus one
  logic                           write_q;

  // ----------------------------
  // Control FSM and strobes
  // ----------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= st_idle;
      cnt          <= '0;
      write_q      <= 1'b0;
      done         <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 4'hf;
      smc_n_we     <= 4'hf;
      smc_n_wr     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state        <= st_setup;
            write_q      <= write;
            cnt          <= write ? wr_wait : rd_wait;
            smc_n_cs     <= 1'b0;
            smc_n_be     <= ~byte_lanes;
            smc_n_ext_oe <= ~write;  // Drive data bus on writes
            smc_busy     <= 1'b1;
          end
        end
        st_setup: begin
          state <= st_strobe;
          if (write_q) begin
            smc_n_wr <= 1'b0;
            smc_n_we <= smc_n_be;  // Same lanes as byte enables
          end else begin
            smc_n_rd <= 1'b0;
          end
        end
        st_strobe: begin
          if (cnt == '0) begin
            state    <= st_hold;
            done     <= 1'b1;
            smc_n_rd <= 1'b1;
            smc_n_wr <= 1'b1;  // Rising edge writes the SRAM
            smc_n_we <= 4'hf;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin  // st_hold, cs still low
          state        <= st_idle;
          done         <= 1'b0;
          smc_n_cs     <= 1'b1;
          smc_n_be     <= 4'hf;
          smc_n_ext_oe <= 1'b1;
          smc_busy     <= 1'b0;
        end
      endcase
    end
  end

  // Address, write data and read capture
  always_ff @(posedge hclk) begin
    if ((state == st_idle) && start) begin
      smc_addr <= addr;
      smc_data <= wdata;
    end
    if ((state == st_strobe) && (cnt == '0) && !write_q) begin
      rdata <= data_smc;  // Last strobe cycle
    end
  end

endmodule

`default_nettype wire

/* design/smc_top.sv */
// Static memory controller top, AHB-lite and APB on one clock hclk
// One SRAM device on a single chip select
// Legal data phase is wait+5 cycles including the completing cycle
// since the start cycle comes before SETUP, an ERROR phase is 2 cycles
`timescale 1ns/1ns
`default_nettype none

module smc_top (
  input  logic        hclk,
  input  logic        arst_n,
  // APB
  input  logic        psel, penable, pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // AHB-lite
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel, hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready, smc_valid,
  output logic [1:0]  smc_hresp,
  // EMI
  input  logic [31:0] data_smc,
  output logic [31:0] smc_addr, smc_data,
  output logic [3:0]  smc_n_be, smc_n_we,
  output logic        smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe,
  output logic        smc_busy
);

  // ----------------------------
  // Internal links
  // ----------------------------
  logic                           start, write, done;
  logic [31:0]                    addr, wdata, rdata;
  logic [3:0]                     byte_lanes;       // Active high lanes
  logic [smc_pkg::wait_width-1:0] rd_wait, wr_wait;

  smc_apb_regs  u_apb_regs  (.*);  // Timing and access count
  smc_ahb_slave u_ahb_slave (.*);  // Bus side
  smc_emi_fsm   u_emi_fsm   (.*);  // Device side

endmodule

`default_nettype wire

/* sim/smc_clk_gen.sv */
// Clock and reset source for the testbench
// hclk period 40 ns, arst_n low for the first 2 rising edges
`timescale 1ns/1ns
`default_nettype none

module smc_clk_gen (
  output logic hclk,
  output logic arst_n
);

  localparam int half_period = 20;

  initial begin
    hclk = 1'b0;
    forever #half_period hclk = ~hclk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge hclk);
    arst_n <= 1'b1;  // Released on an edge, like the stimulus
  end

endmodule

`default_nettype wire

/* sim/smc_sram_model.sv */
// Behavioral asynchronous SRAM, 256 words of 32 bits
// Word index is smc_addr[9:2], upper address bits alias
// Fill pattern is a function of the word index only
`timescale 1ns/1ns
`default_nettype none

module smc_sram_model (
  input  logic        arst_n,
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic [3:0]  smc_n_be,
  input  logic        smc_n_cs,
  input  logic        smc_n_wr,
  input  logic        smc_n_rd,
  output logic [31:0] data_smc
);

  logic [31:0] mem [256];

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h3b};
    end
  end

  // Write on the rising strobe edge, lanes from n_be which is still held
  always @(posedge smc_n_wr) begin
    if (arst_n && !smc_n_cs) begin
      for (int b = 0; b < 4; b++) begin
        if (!smc_n_be[b]) mem[smc_addr[9:2]][8*b +: 8] <= smc_data[8*b +: 8];
      end
    end
  end

  // Read data only while selected and strobed
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[smc_addr[9:2]] : 32'd0;

endmodule

`default_nettype wire

/* sim/smc_asserts.sv */
// EMI strobe and AHB error response checks, bound into smc_top
// Sampled on hclk rising edges, off while arst_n is low
`timescale 1ns/1ns
`default_nettype none

module smc_asserts (
  input logic       hclk,
  input logic       arst_n,
  input logic       smc_n_cs,
  input logic       smc_n_rd,
  input logic       smc_n_wr,
  input logic [3:0] smc_n_we,
  input logic [3:0] smc_n_be,
  input logic       smc_hready,
  input logic [1:0] smc_hresp
);

  // ------------------------------
  // EMI strobes
  // ------------------------------
  strobe_excl: assert property (@(posedge hclk) disable iff (!arst_n)
    !(!smc_n_rd && !smc_n_wr))
    else $error("Read and write strobes low together");

  strobe_in_cs: assert property (@(posedge hclk) disable iff (!arst_n)
    (!smc_n_rd || !smc_n_wr) |-> !smc_n_cs)
    else $error("Strobe low without chip select");

  we_lanes: assert property (@(posedge hclk) disable iff (!arst_n)
    !smc_n_wr |-> (smc_n_we == smc_n_be))  // Write enables follow byte enables
    else $error("Write enables differ from byte enables");

  // ------------------------------
  // AHB ERROR response
  // ------------------------------
  err_two_cycle: assert property (@(posedge hclk) disable iff (!arst_n)
    (smc_hresp == smc_pkg::hresp_error && !smc_hready) |=>
    (smc_hresp == smc_pkg::hresp_error && smc_hready))
    else $error("ERROR response not followed by a ready ERROR cycle");

  err_no_cs: assert property (@(posedge hclk) disable iff (!arst_n)
    (smc_hresp == smc_pkg::hresp_error) |-> smc_n_cs)
    else $error("Chip select low during an ERROR response");

endmodule

bind smc_top smc_asserts u_asserts (.*);

`default_nettype wire

/* sim/smc_tb.sv */
// Testbench for the static memory controller
// Random AHB and APB traffic from a fixed seed, checked against a reference memory
// Reference fill must match the SRAM model pattern
// hready input stays high, only one slave on the bus
`timescale 1ns/1ns
`default_nettype none

module smc_tb;

  localparam int num_xfers   = 200;
  localparam int num_errs    = 20;
  localparam int worst_phase = 24;  // 20-cycle data phase plus gaps
  localparam int max_cycles  = (num_xfers + 2 * num_errs) * worst_phase + 2000;

  logic        hclk, arst_n;
  logic        psel, penable, pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic [31:0] haddr, hwdata, smc_hrdata;
  logic [1:0]  htrans, smc_hresp;
  logic        hsel, hwrite, hready, smc_hready, smc_valid;
  logic [2:0]  hsize;
  logic [31:0] data_smc, smc_addr, smc_data;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  integer      seed = 32'h0ec24b19;
  logic [31:0] ref_mem [256];
  int          errs [1:6];
  int          checks = 0;
  int          cycles = 0;
  int          legal_count = 0;

  smc_clk_gen u_clk (.hclk, .arst_n);
  smc_top u_dut (.*);
  smc_sram_model u_sram (.arst_n, .smc_addr, .smc_data, .smc_n_be, .smc_n_cs,
                         .smc_n_wr, .smc_n_rd, .data_smc);

  // Run limit
  always @(posedge hclk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped completing transfers", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------
  // Checks and models
  // ------------------------------
  task automatic check_val(input int tn, input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errs[tn]++;
    end
  endtask

  task automatic check_true(input int tn, input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Check failed: %s", what);
      errs[tn]++;
    end
  endtask

  task automatic report(input int tn, input string name);
    if (errs[tn] == 0) $display("Test %0d %s: passed", tn, name);
    else $display("Test %0d %s: failed with %0d errors", tn, name, errs[tn]);
  endtask

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3b};
  endfunction

  // Active lanes for a transfer size and low address bits
  function automatic logic [3:0] lanes_for(input logic [2:0] sz, input logic [1:0] lo);
    logic [3:0] l;
    l = 4'b1111;
    if (sz == 3'd0) l = 4'b0001 << lo;
    else if (sz == 3'd1) l = lo[1] ? 4'b1100 : 4'b0011;
    return l;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] l);
    return {{8{l[3]}}, {8{l[2]}}, {8{l[1]}}, {8{l[0]}}};
  endfunction

  // ------------------------------
  // Bus drivers
  // ------------------------------
  task automatic apb_write(input logic [4:0] a, input logic [31:0] d);
    @(posedge hclk);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= a;
    pwdata <= d;
    @(posedge hclk);
    penable <= 1'b1;  // Access phase
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] a, output logic [31:0] d);
    @(posedge hclk);
    psel  <= 1'b1;
    paddr <= a;
    @(negedge hclk);
    d = prdata;  // Combinational while selected
    @(posedge hclk);
    psel <= 1'b0;
  endtask

  // One AHB transfer, phase counts the cycles up to and including the ready one
  // Other counts are EMI pin cycles seen inside the data phase
  task automatic ahb_xfer(input int tn, input logic [31:0] a, input logic wr,
                          input logic [2:0] sz, input logic [31:0] d, input logic exp_ok,
                          output logic [31:0] rdata, output int phase, output int strobe,
                          output int cs_low, output int busy, output int oe_low);
    logic [31:0] exp_resp;
    exp_resp = exp_ok ? 32'(smc_pkg::hresp_okay) : 32'(smc_pkg::hresp_error);
    @(posedge hclk);
    haddr  <= a;
    htrans <= smc_pkg::htrans_nonseq;
    hsel   <= 1'b1;
    hwrite <= wr;
    hsize  <= sz;
    hwdata <= d;  // Held through the data phase
    @(negedge hclk);
    check_val(tn, "smc_valid", 32'(smc_valid), 32'(exp_ok));
    @(posedge hclk);  // Acceptance edge
    htrans <= smc_pkg::htrans_idle;
    hsel   <= 1'b0;
    phase  = 0;
    strobe = 0;
    cs_low = 0;
    busy   = 0;
    oe_low = 0;
    do begin
      @(negedge hclk);
      phase++;
      if (!smc_n_rd || !smc_n_wr) strobe++;
      if (!smc_n_cs) cs_low++;
      if (smc_busy) busy++;
      if (!smc_n_ext_oe) oe_low++;
      check_val(tn, "smc_hresp", 32'(smc_hresp), exp_resp);
    end while (!smc_hready);
    rdata = smc_hrdata;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] r, rnd, a, d, m;
    logic [2:0]  sz;
    logic        wr;
    int          ph, st, cl, bz, oe, w, rd_w, wr_w, total, nfail;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    haddr   = '0;
    htrans  = smc_pkg::htrans_idle;
    hsel    = 1'b0;
    hwrite  = 1'b0;
    hsize   = '0;
    hwdata  = '0;
    hready  = 1'b1;
    rd_w    = 0;
    wr_w    = 0;
    for (int i = 1; i <= 6; i++) errs[i] = 0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i[7:0]);
    wait (arst_n === 1'b1);
    @(negedge hclk);

    // 1. Reset state
    check_val(1, "smc_hready", 32'(smc_hready), 32'd1);
    check_val(1, "smc_hresp", 32'(smc_hresp), 32'(smc_pkg::hresp_okay));
    check_val(1, "smc_n_cs", 32'(smc_n_cs), 32'd1);
    check_val(1, "smc_n_rd", 32'(smc_n_rd), 32'd1);
    check_val(1, "smc_n_wr", 32'(smc_n_wr), 32'd1);
    check_val(1, "smc_n_we", 32'(smc_n_we), 32'hf);
    check_val(1, "smc_n_be", 32'(smc_n_be), 32'hf);
    check_val(1, "smc_n_ext_oe", 32'(smc_n_ext_oe), 32'd1);
    check_val(1, "smc_valid", 32'(smc_valid), 32'd0);
    check_val(1, "smc_busy", 32'(smc_busy), 32'd0);
    apb_read(smc_pkg::reg_timing_addr, r);
    check_val(1, "prdata", r, {24'd0, smc_pkg::wr_wait_reset, smc_pkg::rd_wait_reset});
    report(1, "reset state");

    // 2. APB write, read back, ignored writes
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      d   = $random(seed);
      apb_write(smc_pkg::reg_timing_addr, rnd);
      apb_read(smc_pkg::reg_timing_addr, r);
      check_val(2, "prdata", r, {24'd0, rnd[7:4], rnd[3:0]});
      apb_write({1'b1, d[10:9], 2'b00}, d);  // Unmapped offset
      apb_write(smc_pkg::reg_count_addr, d);
      apb_read(smc_pkg::reg_timing_addr, r);
      check_val(2, "prdata", r, {24'd0, rnd[7:4], rnd[3:0]});
      apb_read(smc_pkg::reg_count_addr, r);
      check_val(2, "prdata", r, 32'd0);  // No access yet
      apb_read({1'b1, d[10:9], 2'b00}, r);
      check_val(2, "prdata", r, 32'd0);
    end
    report(2, "APB registers");

    // 3 and 4. Random legal traffic with strobe timing
    for (int i = 0; i < num_xfers; i++) begin
      if (i % 25 == 0) begin
        rnd  = $random(seed);
        rd_w = int'(rnd[3:0]);
        wr_w = int'(rnd[7:4]);
        apb_write(smc_pkg::reg_timing_addr, {24'd0, rnd[7:0]});
      end
      rnd = $random(seed);
      d   = $random(seed);
      wr  = rnd[31];
      sz  = (rnd[30:29] == 2'd3) ? 3'd2 : {1'b0, rnd[30:29]};
      a   = {22'd0, rnd[9:0]};
      if (sz == 3'd1) a[0] = 1'b0;
      if (sz == 3'd2) a[1:0] = 2'b00;
      m   = lane_mask(lanes_for(sz, a[1:0]));
      ahb_xfer(3, a, wr, sz, d, 1'b1, r, ph, st, cl, bz, oe);
      legal_count++;
      w = wr ? wr_w : rd_w;
      check_true(4, st == w + 1, $sformatf("strobe low %0d cycles, expected %0d", st, w + 1));
      check_true(4, ph == w + 5, $sformatf("data phase %0d cycles, expected %0d", ph, w + 5));
      // SETUP, STROBE and HOLD together
      check_true(4, cl == w + 3,
                 $sformatf("chip select low %0d cycles, expected %0d", cl, w + 3));
      check_true(4, bz == w + 3, $sformatf("busy high %0d cycles, expected %0d", bz, w + 3));
      check_true(4, oe == (wr ? w + 3 : 0),
                 $sformatf("data bus driven %0d cycles, expected %0d", oe, wr ? w + 3 : 0));
      if (wr) ref_mem[a[9:2]] = (ref_mem[a[9:2]] & ~m) | (d & m);
      else check_val(3, "smc_hrdata", r & m, ref_mem[a[9:2]] & m);
    end
    report(3, "random data traffic");
    report(4, "strobe timing");

    // 5. Illegal size or alignment
    for (int i = 0; i < num_errs; i++) begin
      rnd = $random(seed);
      d   = $random(seed);
      wr  = rnd[31];
      a   = {22'd0, rnd[9:0]};
      if (rnd[12]) begin
        sz = 3'd3 + {1'b0, rnd[14:13]};  // Wider than the bus
      end else begin
        sz   = rnd[13] ? 3'd2 : 3'd1;
        a[0] = 1'b1;  // Misaligned
      end
      ahb_xfer(5, a, wr, sz, d, 1'b0, r, ph, st, cl, bz, oe);
      check_true(5, ph == 2, $sformatf("error response took %0d cycles, expected 2", ph));
      check_true(5, cl == 0, "chip select went low on an error transfer");
      check_true(5, bz == 0 && oe == 0, "EMI became busy on an error transfer");
      if (wr) begin
        ahb_xfer(5, {a[31:2], 2'b00}, 1'b0, 3'd2, 32'd0, 1'b1, r, ph, st, cl, bz, oe);
        legal_count++;
        check_val(5, "smc_hrdata", r, ref_mem[a[9:2]]);  // Memory untouched
      end
    end
    report(5, "error transfers");

    // 6. Completed access count
    apb_read(smc_pkg::reg_count_addr, r);
    check_val(6, "prdata", r, 32'(legal_count));
    report(6, "access counter");

    total = 0;
    nfail = 0;
    for (int i = 1; i <= 6; i++) begin
      total += errs[i];
      if (errs[i] != 0) nfail++;
    end
    $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors", nfail, checks, total);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
design/smc_pkg.sv
design/smc_apb_regs.sv
design/smc_ahb_slave.sv
design/smc_emi_fsm.sv
design/smc_top.sv
sim/smc_clk_gen.sv
sim/smc_sram_model.sv
sim/smc_asserts.sv
sim/smc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SMC testbench with Verilator, result taken from the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --assert --timescale 1ns/1ns --top-module smc_tb \
  -Mdir "$obj" -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$obj/Vsmc_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
